// File: Makefile
TOP := tb_load_buffer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

// File: bench/load_buffer_properties.sv
`timescale 1ns/10ps
`default_nettype none

module load_buffer_properties (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  flush_i,
  input logic                  mem_valid_o,
  input logic                  mem_ready_i,
  input lb_pkg::xlen_t         mem_addr_o,
  input lb_pkg::be_t           mem_be_o,
  input lb_pkg::lb_idx_t       mem_tag_o,
  input logic                  result_valid_o,
  input logic                  result_ready_i,
  input lb_pkg::rob_idx_t      result_dest_o,
  input lb_pkg::xlen_t         result_value_o,
  input logic                  result_except_o,
  input lb_pkg::except_code_t  result_code_o
);

  // stalled result keeps its fields
  a_result_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o && !result_ready_i && !flush_i |=>
      result_valid_o && $stable(result_dest_o) && $stable(result_value_o)
      && $stable(result_except_o) && $stable(result_code_o)
  ) else $error("result fields changed while stalled");

  // stalled request keeps its fields
  a_mem_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_valid_o && !mem_ready_i && !flush_i |=>
      mem_valid_o && $stable(mem_addr_o) && $stable(mem_be_o) && $stable(mem_tag_o)
  ) else $error("memory request changed while stalled");

  a_flush_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !mem_valid_o && !result_valid_o
  ) else $error("valid output high after flush");

endmodule

bind load_buffer load_buffer_properties u_load_buffer_properties (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .flush_i         (flush_i),
  .mem_valid_o     (mem_valid_o),
  .mem_ready_i     (mem_ready_i),
  .mem_addr_o      (mem_addr_o),
  .mem_be_o        (mem_be_o),
  .mem_tag_o       (mem_tag_o),
  .result_valid_o  (result_valid_o),
  .result_ready_i  (result_ready_i),
  .result_dest_o   (result_dest_o),
  .result_value_o  (result_value_o),
  .result_except_o (result_except_o),
  .result_code_o   (result_code_o)
);

`default_nettype wire

// File: bench/tb_load_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_load_buffer;
  import lb_pkg::*;

  localparam int unsigned TEST_COUNT      = 6;
  localparam int unsigned CYCLES_PER_TEST = 200;
  localparam int unsigned WAIT_LIMIT      = 50;

  logic         clk_i = 1'b0;
  logic         rst_n_i;
  logic         flush_i;
  logic         issue_valid_i;
  logic         issue_ready_o;
  ld_width_t    issue_width_i;
  logic         issue_rs1_ready_i;
  rob_idx_t     issue_rs1_tag_i;
  xlen_t        issue_rs1_value_i;
  xlen_t        issue_imm_i;
  rob_idx_t     issue_dest_i;
  logic         cdb_valid_i;
  rob_idx_t     cdb_tag_i;
  xlen_t        cdb_value_i;
  logic         mem_valid_o;
  logic         mem_ready_i;
  xlen_t        mem_addr_o;
  be_t          mem_be_o;
  lb_idx_t      mem_tag_o;
  logic         mem_rsp_valid_i;
  lb_idx_t      mem_rsp_tag_i;
  xlen_t        mem_rsp_data_i;
  logic         mem_rsp_except_i;
  except_code_t mem_rsp_code_i;
  logic         result_valid_o;
  logic         result_ready_i;
  rob_idx_t     result_dest_o;
  xlen_t        result_value_o;
  logic         result_except_o;
  except_code_t result_code_o;

  string        test_name;
  // requests taken by the memory model, in acceptance order
  lb_idx_t      req_tag_q  [$];
  xlen_t        req_addr_q [$];
  be_t          req_be_q   [$];

  load_buffer u_load_buffer (.*);

  always #20 clk_i = ~clk_i;

  // outputs are settled by the falling edge
  always @(negedge clk_i) begin : p_req_monitor
    if (rst_n_i && !flush_i && mem_valid_o && mem_ready_i) begin
      req_tag_q.push_back(mem_tag_o);
      req_addr_q.push_back(mem_addr_o);
      req_be_q.push_back(mem_be_o);
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // memory contents as a function of the doubleword address
  function automatic xlen_t mem_word(input xlen_t addr);
    return (addr * 64'h9E37_79B9_7F4A_7C15) ^ {addr[31:0], addr[63:32]};
  endfunction

  function automatic int unsigned width_bytes(input ld_width_t w);
    case (w)
      LD_B, LD_BU: return 1;
      LD_H, LD_HU: return 2;
      LD_W, LD_WU: return 4;
      default:     return 8;
    endcase
  endfunction

  function automatic be_t expected_be(input ld_width_t w, input logic [2:0] off);
    be_t be;
    be = '0;
    for (int unsigned i = 0; i < width_bytes(w); i++) begin
      be[off + i] = 1'b1;
    end
    return be;
  endfunction

  function automatic xlen_t expected_value(input xlen_t dword, input logic [2:0] off,
                                           input ld_width_t w);
    int unsigned nbytes;
    xlen_t       val;
    nbytes = width_bytes(w);
    val = '0;
    for (int unsigned i = 0; i < nbytes; i++) begin
      val[8*i +: 8] = dword[8*(off + i) +: 8];
    end
    // signed codes copy the top loaded bit upward
    if ((w == LD_B || w == LD_H || w == LD_W) && val[8*nbytes - 1]) begin
      for (int unsigned i = nbytes; i < 8; i++) begin
        val[8*i +: 8] = 8'hFF;
      end
    end
    return val;
  endfunction

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic cmp_xlen(input string what, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      abort_run($sformatf("** Error [%s] %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic cmp_rob(input string what, input rob_idx_t exp, input rob_idx_t act);
    if (exp !== act) begin
      abort_run($sformatf("** Error [%s] %s: expected %0d, actual %0d",
                          test_name, what, exp, act));
    end
  endtask

  task automatic cmp_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("** Error [%s] %s: expected %b, actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic cmp_be(input string what, input be_t exp, input be_t act);
    if (exp !== act) begin
      abort_run($sformatf("** Error [%s] %s: expected %b, actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic cmp_code(input string what, input except_code_t exp,
                          input except_code_t act);
    if (exp !== act) begin
      abort_run($sformatf("** Error [%s] %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic cmp_idx(input string what, input lb_idx_t exp, input lb_idx_t act);
    if (exp !== act) begin
      abort_run($sformatf("** Error [%s] %s: expected %0d, actual %0d",
                          test_name, what, exp, act));
    end
  endtask

  // ----------------------------------------
  // bus drivers
  // ----------------------------------------
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic issue_load(input ld_width_t w, input logic rs1_rdy, input rob_idx_t rs1_tag,
                            input xlen_t rs1_val, input xlen_t imm, input rob_idx_t dest);
    int unsigned waited;
    waited = 0;
    issue_valid_i     = 1'b1;
    issue_width_i     = w;
    issue_rs1_ready_i = rs1_rdy;
    issue_rs1_tag_i   = rs1_tag;
    issue_rs1_value_i = rs1_val;
    issue_imm_i       = imm;
    issue_dest_i      = dest;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      if (waited == WAIT_LIMIT) abort_run($sformatf("issue never accepted in %s", test_name));
      @(negedge clk_i);
      waited++;
    end
    step();
    issue_valid_i = 1'b0;
  endtask

  task automatic send_cdb(input rob_idx_t tag, input xlen_t value);
    cdb_valid_i = 1'b1;
    cdb_tag_i   = tag;
    cdb_value_i = value;
    step();
    cdb_valid_i = 1'b0;
  endtask

  task automatic wait_request(output lb_idx_t tag, output xlen_t addr, output be_t be);
    int unsigned waited;
    waited = 0;
    while (req_tag_q.size() == 0) begin
      if (waited == WAIT_LIMIT) abort_run($sformatf("no memory request in %s", test_name));
      step();
      waited++;
    end
    tag  = req_tag_q.pop_front();
    addr = req_addr_q.pop_front();
    be   = req_be_q.pop_front();
  endtask

  task automatic send_response(input lb_idx_t tag, input xlen_t data, input logic exc,
                               input except_code_t code);
    mem_rsp_valid_i  = 1'b1;
    mem_rsp_tag_i    = tag;
    mem_rsp_data_i   = data;
    mem_rsp_except_i = exc;
    mem_rsp_code_i   = code;
    step();
    mem_rsp_valid_i  = 1'b0;
  endtask

  task automatic expect_result(input rob_idx_t dest, input xlen_t value, input logic exc,
                               input except_code_t code);
    int unsigned waited;
    waited = 0;
    result_ready_i = 1'b1;
    @(negedge clk_i);
    while (!result_valid_o) begin
      if (waited == WAIT_LIMIT) abort_run($sformatf("no result in %s", test_name));
      @(negedge clk_i);
      waited++;
    end
    cmp_rob("result dest", dest, result_dest_o);
    cmp_xlen("result value", value, result_value_o);
    cmp_bit("result except", exc, result_except_o);
    cmp_code("result code", code, result_code_o);
    step();
    result_ready_i = 1'b0;
  endtask

  // one ready-operand load from issue to result
  task automatic run_load(input ld_width_t w, input xlen_t base, input xlen_t imm,
                          input rob_idx_t dest);
    xlen_t   addr;
    xlen_t   dw_addr;
    lb_idx_t tag;
    xlen_t   req_addr;
    be_t     be;
    addr    = base + imm;
    dw_addr = {addr[XLEN-1:3], 3'b000};
    issue_load(w, 1'b1, '0, base, imm, dest);
    wait_request(tag, req_addr, be);
    cmp_xlen("request address", dw_addr, req_addr);
    cmp_be("byte enable", expected_be(w, addr[2:0]), be);
    send_response(tag, mem_word(dw_addr), 1'b0, '0);
    expect_result(dest, expected_value(mem_word(dw_addr), addr[2:0], w), 1'b0, '0);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic dword_load();
    xlen_t   base;
    xlen_t   imm;
    xlen_t   dw_addr;
    lb_idx_t tag;
    xlen_t   req_addr;
    be_t     be;
    test_name = "dword_load";
    base = {$urandom(), $urandom()};
    base[2:0] = 3'b000;
    imm = xlen_t'($urandom_range(0, 63)) << 3;
    dw_addr = base + imm;
    // memory stalls first so the request must hold
    mem_ready_i = 1'b0;
    issue_load(LD_D, 1'b1, '0, base, imm, 5'd3);
    repeat (2) step();
    @(negedge clk_i);
    cmp_bit("request pending", 1'b1, mem_valid_o);
    step();
    mem_ready_i = 1'b1;
    wait_request(tag, req_addr, be);
    cmp_idx("request tag", '0, tag);
    cmp_xlen("request address", dw_addr, req_addr);
    cmp_be("byte enable", 8'hFF, be);
    send_response(tag, mem_word(dw_addr), 1'b0, '0);
    expect_result(5'd3, mem_word(dw_addr), 1'b0, '0);
  endtask

  task automatic width_sweep();
    ld_width_t   widths [7];
    int unsigned nbytes;
    xlen_t       base;
    xlen_t       imm;
    rob_idx_t    dest;
    test_name = "width_sweep";
    widths = '{LD_B, LD_BU, LD_H, LD_HU, LD_W, LD_WU, LD_D};
    dest = '0;
    foreach (widths[w]) begin
      nbytes = width_bytes(widths[w]);
      for (int unsigned off = 0; off < 8; off += nbytes) begin
        imm  = xlen_t'($urandom_range(0, 255));
        base = {$urandom(), $urandom()};
        // steer the sum onto the wanted offset
        base[2:0] = 3'(off) - imm[2:0];
        run_load(widths[w], base, imm, dest);
        dest = dest + 5'd1;
      end
    end
  endtask

  task automatic operand_wait();
    xlen_t   base;
    xlen_t   imm;
    xlen_t   addr;
    xlen_t   dw_addr;
    lb_idx_t tag;
    xlen_t   req_addr;
    be_t     be;
    test_name = "operand_wait";
    base = {$urandom(), $urandom()};
    imm  = xlen_t'($urandom_range(0, 255));
    base[2:0] = 3'd2 - imm[2:0];
    addr    = base + imm;
    dw_addr = {addr[XLEN-1:3], 3'b000};
    // stale rs1 value, the real base arrives on the CDB
    issue_load(LD_HU, 1'b0, 5'd12, ~base, imm, 5'd20);
    for (int k = 1; k <= 3; k++) begin
      send_cdb(5'd12 ^ 5'(k), {$urandom(), $urandom()});
      @(negedge clk_i);
      cmp_bit("request before operand", 1'b0, mem_valid_o);
      step();
    end
    send_cdb(5'd12, base);
    wait_request(tag, req_addr, be);
    cmp_xlen("request address", dw_addr, req_addr);
    cmp_be("byte enable", expected_be(LD_HU, 3'd2), be);
    send_response(tag, mem_word(dw_addr), 1'b0, '0);
    expect_result(5'd20, expected_value(mem_word(dw_addr), 3'd2, LD_HU), 1'b0, '0);
  endtask

  task automatic full_reorder();
    xlen_t   addr [4];
    lb_idx_t tag  [4];
    xlen_t   req_addr;
    be_t     be;
    test_name = "full_reorder";
    for (int k = 0; k < 4; k++) begin
      addr[k] = {$urandom(), $urandom()};
      addr[k][2:0] = 3'b000;
      issue_load(LD_D, 1'b1, '0, addr[k], '0, rob_idx_t'(8 + k));
    end
    @(negedge clk_i);
    cmp_bit("issue ready when full", 1'b0, issue_ready_o);
    step();
    for (int k = 0; k < 4; k++) begin
      wait_request(tag[k], req_addr, be);
      cmp_xlen("request address", addr[k], req_addr);
    end
    // youngest answered first
    for (int k = 3; k >= 0; k--) begin
      send_response(tag[k], mem_word(addr[k]), 1'b0, '0);
      if (k == 1) begin
        @(negedge clk_i);
        cmp_bit("result before head done", 1'b0, result_valid_o);
        step();
      end
    end
    // results stall under back-pressure
    repeat (3) step();
    for (int k = 0; k < 4; k++) begin
      expect_result(rob_idx_t'(8 + k), mem_word(addr[k]), 1'b0, '0);
    end
  endtask

  task automatic mem_exception();
    xlen_t   base;
    xlen_t   imm;
    xlen_t   addr;
    lb_idx_t tag;
    xlen_t   req_addr;
    be_t     be;
    test_name = "mem_exception";
    base = {$urandom(), $urandom()};
    imm  = xlen_t'($urandom_range(0, 255));
    base[2:0] = 3'd4 - imm[2:0];
    addr = base + imm;
    issue_load(LD_W, 1'b1, '0, base, imm, 5'd27);
    wait_request(tag, req_addr, be);
    send_response(tag, {$urandom(), $urandom()}, 1'b1, 4'h5);
    expect_result(5'd27, addr, 1'b1, 4'h5);
  endtask

  task automatic flush_recovery();
    xlen_t   base;
    lb_idx_t tag;
    xlen_t   req_addr;
    be_t     be;
    test_name = "flush_recovery";
    base = {$urandom(), $urandom()};
    // oldest load completes and waits at the head
    issue_load(LD_D, 1'b1, '0, {base[XLEN-1:3], 3'b000}, 64'h40, 5'd5);
    wait_request(tag, req_addr, be);
    send_response(tag, mem_word(req_addr), 1'b0, '0);
    // memory stalls so the younger loads stay pending and the buffer fills
    mem_ready_i = 1'b0;
    issue_load(LD_W, 1'b1, '0, {$urandom(), $urandom()}, 64'h8, 5'd6);
    issue_load(LD_H, 1'b0, 5'd7, '0, 64'h10, 5'd7);
    issue_load(LD_BU, 1'b1, '0, {$urandom(), $urandom()}, 64'h3, 5'd8);
    flush_i = 1'b1;
    step();
    flush_i     = 1'b0;
    mem_ready_i = 1'b1;
    @(negedge clk_i);
    cmp_bit("issue ready after flush", 1'b1, issue_ready_o);
    cmp_bit("result valid after flush", 1'b0, result_valid_o);
    cmp_bit("request valid after flush", 1'b0, mem_valid_o);
    step();
    run_load(LD_B, {$urandom(), $urandom()}, xlen_t'($urandom_range(0, 255)), 5'd9);
  endtask

  // ----------------------------------------
  // run control
  // ----------------------------------------
  initial begin : p_watchdog
    repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk_i);
    abort_run($sformatf("watchdog expired during %s", test_name));
  end

  initial begin : p_main
    void'($urandom(77));
    test_name         = "reset";
    rst_n_i           = 1'b0;
    flush_i           = 1'b0;
    issue_valid_i     = 1'b0;
    issue_width_i     = LD_D;
    issue_rs1_ready_i = 1'b0;
    issue_rs1_tag_i   = '0;
    issue_rs1_value_i = '0;
    issue_imm_i       = '0;
    issue_dest_i      = '0;
    cdb_valid_i       = 1'b0;
    cdb_tag_i         = '0;
    cdb_value_i       = '0;
    mem_ready_i       = 1'b1;
    mem_rsp_valid_i   = 1'b0;
    mem_rsp_tag_i     = '0;
    mem_rsp_data_i    = '0;
    mem_rsp_except_i  = 1'b0;
    mem_rsp_code_i    = '0;
    result_ready_i    = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    dword_load();
    width_sweep();
    operand_wait();
    full_reorder();
    mem_exception();
    flush_recovery();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/lb_commit.sv
`timescale 1ns/10ps
`default_nettype none

module lb_commit (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output lb_pkg::rob_idx_t      result_dest_o,
  output lb_pkg::xlen_t         result_value_o,
  output logic                  result_except_o,
  output lb_pkg::except_code_t  result_code_o,
  lb_entry_if.commit            ent [lb_pkg::LB_DEPTH]
);
  import lb_pkg::*;

  lb_idx_t      head_q;
  logic         pop;
  logic         ent_done   [LB_DEPTH];
  xlen_t        ent_value  [LB_DEPTH];
  rob_idx_t     ent_dest   [LB_DEPTH];
  logic         ent_except [LB_DEPTH];
  except_code_t ent_code   [LB_DEPTH];

  for (genvar i = 0; i < LB_DEPTH; i++) begin : g_ent
    assign ent_done[i]   = (ent[i].state == LB_DONE);
    assign ent_value[i]  = ent[i].res_value;
    assign ent_dest[i]   = ent[i].res_dest;
    assign ent_except[i] = ent[i].res_except;
    assign ent_code[i]   = ent[i].res_code;
    assign ent[i].pop    = pop && (head_q == lb_idx_t'(i));
  end

  // results leave strictly from the head
  assign result_valid_o  = ent_done[head_q];
  assign result_value_o  = ent_value[head_q];
  assign result_dest_o   = ent_dest[head_q];
  assign result_except_o = ent_except[head_q];
  assign result_code_o   = ent_code[head_q];
  assign pop             = result_valid_o && result_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : p_head
    if (!rst_n_i) begin
      head_q <= '0;
    end else if (flush_i) begin
      head_q <= '0;
    end else if (pop) begin
      head_q <= (head_q == lb_idx_t'(LB_DEPTH - 1)) ? '0 : head_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lb_entry.sv
`timescale 1ns/10ps
`default_nettype none

module lb_entry #(
  parameter int unsigned ENTRY_IDX = 0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              cdb_valid_i,
  input  lb_pkg::rob_idx_t  cdb_tag_i,
  input  lb_pkg::xlen_t     cdb_value_i,
  lb_alloc_if.entry         alloc,
  lb_entry_if.entry         ent
);
  import lb_pkg::*;

  lb_state_t    state_q;
  lb_state_t    state_d;
  ld_width_t    width_q;
  rob_idx_t     rs1_tag_q;
  xlen_t        base_q;
  xlen_t        imm_q;
  rob_idx_t     dest_q;
  xlen_t        res_value_q;
  logic         res_except_q;
  except_code_t res_code_q;
  xlen_t        eff_addr;
  logic         push_hit;
  logic         cdb_hit;
  logic         rsp_hit;

  assign push_hit = alloc.push && (alloc.idx == lb_idx_t'(ENTRY_IDX))
                    && (state_q == LB_EMPTY);
  // a broadcast in the push cycle is missed, the tag is not stored yet
  assign cdb_hit  = cdb_valid_i && (state_q == LB_RS1_WAIT) && (cdb_tag_i == rs1_tag_q);
  assign rsp_hit  = ent.rsp_valid
                    && ((state_q == LB_MEM_REQ) || (state_q == LB_MEM_WAIT));

  assign eff_addr = base_q + imm_q;

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_comb begin : p_next_state
    state_d = state_q;
    case (state_q)
      LB_EMPTY: begin
        if (push_hit) begin
          state_d = alloc.rs1_ready ? LB_MEM_REQ : LB_RS1_WAIT;
        end
      end
      LB_RS1_WAIT: begin
        if (cdb_hit) state_d = LB_MEM_REQ;
      end
      LB_MEM_REQ: begin
        if (rsp_hit) state_d = LB_DONE;
        else if (ent.mem_issued) state_d = LB_MEM_WAIT;
      end
      LB_MEM_WAIT: begin
        if (rsp_hit) state_d = LB_DONE;
      end
      LB_DONE: begin
        if (ent.pop) state_d = LB_EMPTY;
      end
      default: state_d = LB_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : p_state
    if (!rst_n_i) begin
      state_q <= LB_EMPTY;
    end else if (flush_i) begin
      state_q <= LB_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // stored operands and result
  // ----------------------------------------
  always_ff @(posedge clk_i) begin : p_payload
    if (push_hit) begin
      width_q   <= alloc.width;
      rs1_tag_q <= alloc.rs1_tag;
      base_q    <= alloc.rs1_value;
      imm_q     <= alloc.imm;
      dest_q    <= alloc.dest;
    end else if (cdb_hit) begin
      base_q <= cdb_value_i;
    end
    if (rsp_hit) begin
      // faulting loads report their address as the value
      res_value_q  <= ent.rsp_except ? eff_addr : ent.rsp_data;
      res_except_q <= ent.rsp_except;
      res_code_q   <= ent.rsp_code;
    end
  end

  assign ent.state      = state_q;
  assign ent.addr       = eff_addr;
  assign ent.width      = width_q;
  assign ent.res_value  = res_value_q;
  assign ent.res_dest   = dest_q;
  assign ent.res_except = res_except_q;
  assign ent.res_code   = res_code_q;

endmodule

`default_nettype wire

// File: rtl/lb_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// allocation broadcast from the issue controller to all entries
interface lb_alloc_if;
  import lb_pkg::*;

  logic      push;
  lb_idx_t   idx;
  ld_width_t width;
  logic      rs1_ready;
  rob_idx_t  rs1_tag;
  xlen_t     rs1_value;
  xlen_t     imm;
  rob_idx_t  dest;

  modport issuer (
    output push, idx, width, rs1_ready, rs1_tag, rs1_value, imm, dest
  );

  modport entry (
    input push, idx, width, rs1_ready, rs1_tag, rs1_value, imm, dest
  );

endinterface

// per-entry status, contents and strobes
interface lb_entry_if;
  import lb_pkg::*;

  lb_state_t    state;
  xlen_t        addr;
  ld_width_t    width;
  xlen_t        res_value;
  rob_idx_t     res_dest;
  logic         res_except;
  except_code_t res_code;

  // strobes towards the entry
  logic         mem_issued;
  logic         rsp_valid;
  xlen_t        rsp_data;
  logic         rsp_except;
  except_code_t rsp_code;
  logic         pop;

  modport entry (
    output state, addr, width, res_value, res_dest, res_except, res_code,
    input  mem_issued, rsp_valid, rsp_data, rsp_except, rsp_code, pop
  );

  modport status (input state);

  modport memory (
    input  state, addr, width,
    output mem_issued, rsp_valid, rsp_data, rsp_except, rsp_code
  );

  modport commit (
    input  state, res_value, res_dest, res_except, res_code,
    output pop
  );

endinterface

`default_nettype wire

// File: rtl/lb_issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module lb_issue_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                issue_valid_i,
  output logic                issue_ready_o,
  input  lb_pkg::ld_width_t   issue_width_i,
  input  logic                issue_rs1_ready_i,
  input  lb_pkg::rob_idx_t    issue_rs1_tag_i,
  input  lb_pkg::xlen_t       issue_rs1_value_i,
  input  lb_pkg::xlen_t       issue_imm_i,
  input  lb_pkg::rob_idx_t    issue_dest_i,
  lb_alloc_if.issuer          alloc,
  lb_entry_if.status          ent [lb_pkg::LB_DEPTH]
);
  import lb_pkg::*;

  lb_idx_t tail_q;
  logic    push;
  logic    ent_empty [LB_DEPTH];

  for (genvar i = 0; i < LB_DEPTH; i++) begin : g_empty
    assign ent_empty[i] = (ent[i].state == LB_EMPTY);
  end

  // only the slot at the tail may take a new load
  assign issue_ready_o = ent_empty[tail_q];
  assign push          = issue_valid_i && issue_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : p_tail
    if (!rst_n_i) begin
      tail_q <= '0;
    end else if (flush_i) begin
      tail_q <= '0;
    end else if (push) begin
      tail_q <= (tail_q == lb_idx_t'(LB_DEPTH - 1)) ? '0 : tail_q + 1'b1;
    end
  end

  assign alloc.push      = push;
  assign alloc.idx       = tail_q;
  assign alloc.width     = issue_width_i;
  assign alloc.rs1_ready = issue_rs1_ready_i;
  assign alloc.rs1_tag   = issue_rs1_tag_i;
  assign alloc.rs1_value = issue_rs1_value_i;
  assign alloc.imm       = issue_imm_i;
  assign alloc.dest      = issue_dest_i;

endmodule

`default_nettype wire

// File: rtl/lb_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module lb_mem_port (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  output lb_pkg::xlen_t         mem_addr_o,
  output lb_pkg::be_t           mem_be_o,
  output lb_pkg::lb_idx_t       mem_tag_o,
  input  logic                  mem_rsp_valid_i,
  input  lb_pkg::lb_idx_t       mem_rsp_tag_i,
  input  lb_pkg::xlen_t         mem_rsp_data_i,
  input  logic                  mem_rsp_except_i,
  input  lb_pkg::except_code_t  mem_rsp_code_i,
  lb_entry_if.memory            ent [lb_pkg::LB_DEPTH]
);
  import lb_pkg::*;

  lb_idx_t   mem_ptr_q;
  logic      mem_accept;
  logic      ent_req   [LB_DEPTH];
  xlen_t     ent_addr  [LB_DEPTH];
  ld_width_t ent_width [LB_DEPTH];
  ld_width_t req_width;
  be_t       be_base;
  logic [2:0] rsp_off;
  xlen_t     rsp_shifted;
  xlen_t     rsp_ext;

  // ----------------------------------------
  // request side
  // ----------------------------------------
  assign mem_valid_o = ent_req[mem_ptr_q];
  assign mem_accept  = mem_valid_o && mem_ready_i;
  assign mem_tag_o   = mem_ptr_q;
  // memory always sees a doubleword-aligned address
  assign mem_addr_o  = {ent_addr[mem_ptr_q][XLEN-1:3], 3'b000};
  assign req_width   = ent_width[mem_ptr_q];

  always_comb begin : p_be
    case (req_width)
      LD_B, LD_BU: be_base = 8'b0000_0001;
      LD_H, LD_HU: be_base = 8'b0000_0011;
      LD_W, LD_WU: be_base = 8'b0000_1111;
      LD_D:        be_base = 8'b1111_1111;
      default:     be_base = 8'b0000_0000;
    endcase
  end

  assign mem_be_o = be_base << ent_addr[mem_ptr_q][2:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin : p_mem_ptr
    if (!rst_n_i) begin
      mem_ptr_q <= '0;
    end else if (flush_i) begin
      mem_ptr_q <= '0;
    end else if (mem_accept) begin
      mem_ptr_q <= (mem_ptr_q == lb_idx_t'(LB_DEPTH - 1)) ? '0 : mem_ptr_q + 1'b1;
    end
  end

  // ----------------------------------------
  // response side
  // ----------------------------------------
  assign rsp_off     = ent_addr[mem_rsp_tag_i][2:0];
  assign rsp_shifted = mem_rsp_data_i >> {rsp_off, 3'b000};

  always_comb begin : p_extend
    case (ent_width[mem_rsp_tag_i])
      LD_B:    rsp_ext = {{(XLEN-8){rsp_shifted[7]}}, rsp_shifted[7:0]};
      LD_BU:   rsp_ext = {{(XLEN-8){1'b0}}, rsp_shifted[7:0]};
      LD_H:    rsp_ext = {{(XLEN-16){rsp_shifted[15]}}, rsp_shifted[15:0]};
      LD_HU:   rsp_ext = {{(XLEN-16){1'b0}}, rsp_shifted[15:0]};
      LD_W:    rsp_ext = {{(XLEN-32){rsp_shifted[31]}}, rsp_shifted[31:0]};
      LD_WU:   rsp_ext = {{(XLEN-32){1'b0}}, rsp_shifted[31:0]};
      default: rsp_ext = rsp_shifted;
    endcase
  end

  // per-entry status in, strobes out
  for (genvar i = 0; i < LB_DEPTH; i++) begin : g_ent
    assign ent_req[i]        = (ent[i].state == LB_MEM_REQ);
    assign ent_addr[i]       = ent[i].addr;
    assign ent_width[i]      = ent[i].width;
    assign ent[i].mem_issued = mem_accept && (mem_ptr_q == lb_idx_t'(i));
    assign ent[i].rsp_valid  = mem_rsp_valid_i && (mem_rsp_tag_i == lb_idx_t'(i));
    assign ent[i].rsp_data   = rsp_ext;
    assign ent[i].rsp_except = mem_rsp_except_i;
    assign ent[i].rsp_code   = mem_rsp_code_i;
  end

endmodule

`default_nettype wire

// File: rtl/lb_pkg.sv
`default_nettype none

package lb_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned XLEN      = 64;
  localparam int unsigned LB_DEPTH  = 4;
  localparam int unsigned LB_IDX_W  = 2;
  localparam int unsigned ROB_IDX_W = 5;
  localparam int unsigned EXC_W     = 4;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [LB_IDX_W-1:0]  lb_idx_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [EXC_W-1:0]     except_code_t;
  typedef logic [2:0]           ld_width_t;
  typedef logic [7:0]           be_t;

  // ----------------------------------------
  // load-width codes
  // ----------------------------------------
  // same encoding as the funct3 field of the load opcode
  localparam ld_width_t LD_B  = 3'b000;
  localparam ld_width_t LD_H  = 3'b001;
  localparam ld_width_t LD_W  = 3'b010;
  localparam ld_width_t LD_D  = 3'b011;
  localparam ld_width_t LD_BU = 3'b100;
  localparam ld_width_t LD_HU = 3'b101;
  localparam ld_width_t LD_WU = 3'b110;

  // ----------------------------------------
  // entry state
  // ----------------------------------------
  typedef enum logic [2:0] {
    LB_EMPTY,
    LB_RS1_WAIT,
    LB_MEM_REQ,
    LB_MEM_WAIT,
    LB_DONE
  } lb_state_t;

endpackage

`default_nettype wire

// File: rtl/load_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module load_buffer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,

  // issue stage
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  input  lb_pkg::ld_width_t     issue_width_i,
  input  logic                  issue_rs1_ready_i,
  input  lb_pkg::rob_idx_t      issue_rs1_tag_i,
  input  lb_pkg::xlen_t         issue_rs1_value_i,
  input  lb_pkg::xlen_t         issue_imm_i,
  input  lb_pkg::rob_idx_t      issue_dest_i,

  // operand broadcast
  input  logic                  cdb_valid_i,
  input  lb_pkg::rob_idx_t      cdb_tag_i,
  input  lb_pkg::xlen_t         cdb_value_i,

  // memory
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  output lb_pkg::xlen_t         mem_addr_o,
  output lb_pkg::be_t           mem_be_o,
  output lb_pkg::lb_idx_t       mem_tag_o,
  input  logic                  mem_rsp_valid_i,
  input  lb_pkg::lb_idx_t       mem_rsp_tag_i,
  input  lb_pkg::xlen_t         mem_rsp_data_i,
  input  logic                  mem_rsp_except_i,
  input  lb_pkg::except_code_t  mem_rsp_code_i,

  // result
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output lb_pkg::rob_idx_t      result_dest_o,
  output lb_pkg::xlen_t         result_value_o,
  output logic                  result_except_o,
  output lb_pkg::except_code_t  result_code_o
);
  import lb_pkg::*;

  lb_alloc_if alloc_if ();
  lb_entry_if ent_if [LB_DEPTH] ();

  lb_issue_ctrl u_issue_ctrl (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .issue_valid_i     (issue_valid_i),
    .issue_ready_o     (issue_ready_o),
    .issue_width_i     (issue_width_i),
    .issue_rs1_ready_i (issue_rs1_ready_i),
    .issue_rs1_tag_i   (issue_rs1_tag_i),
    .issue_rs1_value_i (issue_rs1_value_i),
    .issue_imm_i       (issue_imm_i),
    .issue_dest_i      (issue_dest_i),
    .alloc             (alloc_if),
    .ent               (ent_if)
  );

  for (genvar i = 0; i < LB_DEPTH; i++) begin : g_entry
    lb_entry #(
      .ENTRY_IDX (i)
    ) u_entry (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .flush_i     (flush_i),
      .cdb_valid_i (cdb_valid_i),
      .cdb_tag_i   (cdb_tag_i),
      .cdb_value_i (cdb_value_i),
      .alloc       (alloc_if),
      .ent         (ent_if[i])
    );
  end

  lb_mem_port u_mem_port (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .mem_valid_o      (mem_valid_o),
    .mem_ready_i      (mem_ready_i),
    .mem_addr_o       (mem_addr_o),
    .mem_be_o         (mem_be_o),
    .mem_tag_o        (mem_tag_o),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_tag_i    (mem_rsp_tag_i),
    .mem_rsp_data_i   (mem_rsp_data_i),
    .mem_rsp_except_i (mem_rsp_except_i),
    .mem_rsp_code_i   (mem_rsp_code_i),
    .ent              (ent_if)
  );

  lb_commit u_commit (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .result_valid_o  (result_valid_o),
    .result_ready_i  (result_ready_i),
    .result_dest_o   (result_dest_o),
    .result_value_o  (result_value_o),
    .result_except_o (result_except_o),
    .result_code_o   (result_code_o),
    .ent             (ent_if)
  );

endmodule

`default_nettype wire

// File: vlog.f
rtl/lb_pkg.sv
rtl/lb_ifs.sv
rtl/lb_issue_ctrl.sv
rtl/lb_entry.sv
rtl/lb_mem_port.sv
rtl/lb_commit.sv
rtl/load_buffer.sv
bench/load_buffer_properties.sv
bench/tb_load_buffer.sv
